/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define REG_ADDR_WIDTH  5              // register file index width
`define ISA_WIDTH       32             // instruction word and pc width
`define PC_MAX_VALUE    32'h0000_3ffc  // last word address held in instruction memory

`define STAGE_CNT       4              // number of pipeline stage registers
`define STG_IF          0              // if/id register
`define STG_ID          1              // id/ex register
`define STG_EX          2              // ex/mem register
`define STG_MEM         3              // mem/wb register

`endif

/* src/isa_pkg.sv */
`include "cpu_params.svh"

package isa_pkg;

    // r-format overlay, i and j formats reuse the upper fields
    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } instr_fields_t;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] funct_jr = 6'h08;

    localparam logic [`REG_ADDR_WIDTH-1:0] reg_ra = `REG_ADDR_WIDTH'(31);  // jal link register

    typedef struct packed {
        logic                       r_type;
        logic                       i_type;
        logic                       jump;       // plain j only
        logic                       jal;
        logic                       jr;
        logic                       branch;     // beq or bne
        logic                       store;
        logic                       load;
        logic                       reg_write;  // writes a nonzero register
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] dest;
    } id_info_t;

endpackage

/* src/ctrl_pkg.sv */
`include "cpu_params.svh"

package ctrl_pkg;

    typedef enum logic [1:0] {
        ctrl_normal = 2'd0,  // register loads its predecessor
        ctrl_hold   = 2'd1,  // register keeps its value
        ctrl_no_op  = 2'd2   // register loads a bubble
    } stage_ctrl_t;

    typedef stage_ctrl_t [`STAGE_CNT-1:0] ctrl_vec_t;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_execute   = 2'd1,
        st_hazard    = 2'd2,
        st_interrupt = 2'd3
    } cpu_state_t;

    typedef enum logic [2:0] {
        iss_none   = 3'd0,
        iss_data   = 3'd1,
        iss_uart   = 3'd2,
        iss_pause  = 3'd3,
        iss_keypad = 3'd4
    } issue_t;

    typedef struct packed {
        logic                       reg_write;
        logic                       mem_read;  // load, result only ready after mem
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic                       no_op;     // stage holds a bubble
    } stage_info_t;

    localparam stage_info_t stage_bubble = '{reg_write: 1'b0, mem_read: 1'b0,
                                             dest: '0, no_op: 1'b1};

    typedef struct packed {
        cpu_state_t cpu_state;
        issue_t     issue;
    } status_msg_t;

    // same code on every stage register
    function automatic ctrl_vec_t fill_ctrl(stage_ctrl_t c);
        ctrl_vec_t v;
        for (int i = 0; i < `STAGE_CNT; i++) begin
            v[i] = c;
        end
        return v;
    endfunction

endpackage

/* src/instr_classifier.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_classifier (
    input  logic [`ISA_WIDTH-1:0] instr,    // word sitting in if/id
    output isa_pkg::id_info_t     id_info
);
    import isa_pkg::*;

    instr_fields_t f;
    logic          rtype_op;
    logic          writes;                  // class that has a destination at all

    assign f        = instr_fields_t'(instr);
    assign rtype_op = (f.opcode == op_rtype);

    always_comb begin
        id_info        = '0;
        id_info.r_type = rtype_op;
        id_info.jump   = (f.opcode == op_j);
        id_info.jal    = (f.opcode == op_jal);
        id_info.jr     = rtype_op && (f.funct == funct_jr);
        id_info.branch = (f.opcode == op_beq) || (f.opcode == op_bne);
        id_info.store  = (f.opcode == op_sw);
        id_info.load   = (f.opcode == op_lw);
        id_info.i_type = !rtype_op && !id_info.jump && !id_info.jal;  // loads, stores, branches too
        id_info.rs     = f.rs;
        id_info.rt     = f.rt;

        if (rtype_op) begin
            id_info.dest = f.rd;            // alu result goes to rd
        end else if (id_info.jal) begin
            id_info.dest = reg_ra;          // link address
        end else begin
            id_info.dest = f.rt;            // loads and alu immediates
        end

        // jr, stores, branches and j leave the register file alone
        writes = !(id_info.jr || id_info.store || id_info.branch || id_info.jump);
        id_info.reg_write = writes && (id_info.dest != '0);  // $zero never counts
    end

endmodule

/* src/stage_tracker.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module stage_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  isa_pkg::id_info_t     id_info,
    input  ctrl_pkg::ctrl_vec_t   stage_ctrl,
    output ctrl_pkg::stage_info_t ex_info,   // instruction now in execute
    output ctrl_pkg::stage_info_t mem_info   // instruction now in memory
);
    import ctrl_pkg::*;

    stage_info_t id_rec;                     // decode instruction in record form

    assign id_rec = '{reg_write: id_info.reg_write, mem_read: id_info.load,
                      dest: id_info.dest, no_op: 1'b0};

    // one stage register step under its control code
    function automatic stage_info_t step(stage_ctrl_t c, stage_info_t cur, stage_info_t prev);
        case (c)
            ctrl_hold:  return cur;
            ctrl_no_op: return stage_bubble;
            default:    return prev;         // normal shift
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_info  <= stage_bubble;
            mem_info <= stage_bubble;
        end else begin
            ex_info  <= step(stage_ctrl[`STG_EX], ex_info, id_rec);
            mem_info <= step(stage_ctrl[`STG_MEM], mem_info, ex_info);  // uses old ex_info
        end
    end

    // the hazard unit only ever bubbles this register, holding it would
    // keep a stale producer in execute and the data hazard would never clear
    a_ex_never_held: assert property (@(posedge clk) disable iff (!rst_n)
        stage_ctrl[`STG_EX] != ctrl_hold);

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module hazard_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  isa_pkg::id_info_t     id_info,
    input  ctrl_pkg::stage_info_t ex_info,
    input  ctrl_pkg::stage_info_t mem_info,
    input  logic [`ISA_WIDTH-1:0] pc_next,               // from instruction memory
    input  logic                  uart_complete,         // uart loader finished
    input  logic                  keypad_read_enable,    // data memory reads the keypad
    input  logic                  keypad_read_complete,  // user pressed enter
    input  logic                  cpu_pause,
    input  logic                  cpu_resume,
    output ctrl_pkg::ctrl_vec_t   stage_ctrl,
    output ctrl_pkg::cpu_state_t  cpu_state,
    output ctrl_pkg::issue_t      issue,
    output logic                  uart_disable           // uart loader held in reset
);
    import ctrl_pkg::*;

    logic rs_used;
    logic rt_used;
    logic ex_conflict;
    logic mem_conflict;
    logic data_hazard;
    logic uart_hazard;
    logic keypad_interrupt;
    logic hazard_resolved;

    // a live producer whose dest feeds a source the decode instruction reads
    function automatic logic conflict(stage_info_t s, logic use_rs, logic use_rt,
                                      logic [`REG_ADDR_WIDTH-1:0] rs,
                                      logic [`REG_ADDR_WIDTH-1:0] rt);
        return s.reg_write && !s.no_op &&
               ((use_rs && (rs == s.dest)) || (use_rt && (rt == s.dest)));
    endfunction

    assign rs_used      = !(id_info.jump || id_info.jal);
    assign rt_used      = id_info.r_type || id_info.store || id_info.branch;
    assign ex_conflict  = conflict(ex_info, rs_used, rt_used, id_info.rs, id_info.rt);
    assign mem_conflict = conflict(mem_info, rs_used, rt_used, id_info.rs, id_info.rt);

    assign data_hazard = (id_info.branch && (ex_conflict || mem_conflict))  // branch compares in id
                       || (ex_info.mem_read && ex_conflict);                // load-use
    assign uart_hazard      = pc_next > `PC_MAX_VALUE;   // ran off the end of imem
    assign keypad_interrupt = keypad_read_enable && !keypad_read_complete;

    assign hazard_resolved = ((issue == iss_data)  && !data_hazard)
                          || ((issue == iss_uart)  && uart_complete)
                          || ((issue == iss_pause) && cpu_resume && uart_complete);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_state    <= st_idle;
            issue        <= iss_none;
            uart_disable <= 1'b1;
            stage_ctrl   <= fill_ctrl(ctrl_normal);
        end else begin
            case (cpu_state)
                st_execute: begin
                    if (data_hazard) begin                    // wins over everything
                        issue                   <= iss_data;
                        cpu_state               <= st_hazard;
                        stage_ctrl[`STG_IF]     <= ctrl_hold;
                        stage_ctrl[`STG_ID]     <= ctrl_hold;
                        stage_ctrl[`STG_EX]     <= ctrl_no_op;  // producer moves on, bubble behind it
                    end else if (cpu_pause || uart_hazard) begin
                        issue                   <= cpu_pause ? iss_pause : iss_uart;
                        cpu_state               <= st_hazard;
                        uart_disable            <= 1'b0;      // let the loader run
                        stage_ctrl[`STG_IF]     <= ctrl_no_op;  // drain the pipe behind fetch
                    end else if (keypad_interrupt) begin
                        issue                   <= iss_keypad;
                        cpu_state               <= st_interrupt;
                        stage_ctrl              <= fill_ctrl(ctrl_no_op);
                    end
                end
                st_hazard: begin
                    if (hazard_resolved) begin
                        issue        <= iss_none;
                        cpu_state    <= st_execute;
                        uart_disable <= 1'b1;
                        stage_ctrl   <= fill_ctrl(ctrl_normal);
                    end
                end
                st_interrupt: begin
                    if (keypad_read_complete) begin           // user entered the value
                        issue      <= iss_none;
                        cpu_state  <= st_execute;
                        stage_ctrl <= fill_ctrl(ctrl_normal);
                    end
                end
                default: cpu_state <= st_execute;              // idle only lasts one cycle
            endcase
        end
    end

    // the loader may only run while the pipe is parked on a pause or uart issue
    a_uart_only_parked: assert property (@(posedge clk) disable iff (!rst_n)
        !uart_disable |-> (cpu_state == st_hazard) &&
                          ((issue == iss_pause) || (issue == iss_uart)));

endmodule

/* src/status_reporter.sv */
`timescale 1ns/1ps

module status_reporter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ctrl_pkg::cpu_state_t  cpu_state,
    input  ctrl_pkg::issue_t      issue,
    output logic                  disp_req,
    output ctrl_pkg::status_msg_t disp_msg,  // also the last status sent
    input  logic                  disp_ack
);
    import ctrl_pkg::*;

    typedef enum logic [1:0] {
        tx_idle,                             // compare status against last sent
        tx_wait_ack,                         // req high, waiting for ack
        tx_wait_release                      // req dropped, waiting for ack low
    } tx_state_t;

    tx_state_t   tx_state;
    status_msg_t cur_msg;

    assign cur_msg = '{cpu_state: cpu_state, issue: issue};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= tx_idle;
            disp_req <= 1'b0;
            disp_msg <= '{cpu_state: st_idle, issue: iss_none};  // matches status out of reset
        end else begin
            case (tx_state)
                tx_idle: begin
                    if (cur_msg != disp_msg) begin  // changes during a transfer coalesce here
                        disp_msg <= cur_msg;
                        disp_req <= 1'b1;
                        tx_state <= tx_wait_ack;
                    end
                end
                tx_wait_ack: begin
                    if (disp_ack) begin
                        disp_req <= 1'b0;
                        tx_state <= tx_wait_release;
                    end
                end
                default: begin
                    if (!disp_ack) tx_state <= tx_idle;
                end
            endcase
        end
    end

    a_req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(disp_req) |-> $past(disp_ack));

endmodule

/* src/pipeline_control_top.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module pipeline_control_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`ISA_WIDTH-1:0] instr,                 // decode stage word
    input  logic [`ISA_WIDTH-1:0] pc_next,
    input  logic                  uart_complete,
    input  logic                  keypad_read_enable,
    input  logic                  keypad_read_complete,
    input  logic                  cpu_pause,
    input  logic                  cpu_resume,
    output ctrl_pkg::ctrl_vec_t   stage_ctrl,            // to the stage registers
    output ctrl_pkg::cpu_state_t  cpu_state,
    output ctrl_pkg::issue_t      issue,
    output logic                  uart_disable,
    output logic                  disp_req,              // display channel
    output ctrl_pkg::status_msg_t disp_msg,
    input  logic                  disp_ack
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    id_info_t    id_info;
    stage_info_t ex_info;
    stage_info_t mem_info;

    instr_classifier u_classifier (
        .instr   (instr),
        .id_info (id_info)
    );

    stage_tracker u_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_info    (id_info),
        .stage_ctrl (stage_ctrl),
        .ex_info    (ex_info),
        .mem_info   (mem_info)
    );

    hazard_unit u_hazard (
        .clk                  (clk),
        .rst_n                (rst_n),
        .id_info              (id_info),
        .ex_info              (ex_info),
        .mem_info             (mem_info),
        .pc_next              (pc_next),
        .uart_complete        (uart_complete),
        .keypad_read_enable   (keypad_read_enable),
        .keypad_read_complete (keypad_read_complete),
        .cpu_pause            (cpu_pause),
        .cpu_resume           (cpu_resume),
        .stage_ctrl           (stage_ctrl),
        .cpu_state            (cpu_state),
        .issue                (issue),
        .uart_disable         (uart_disable)
    );

    status_reporter u_reporter (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_state (cpu_state),
        .issue     (issue),
        .disp_req  (disp_req),
        .disp_msg  (disp_msg),
        .disp_ack  (disp_ack)
    );

endmodule

/* verification/tb_pipeline_control.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_pipeline_control;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int RUN_CYCLES     = 3000;                 // random stimulus
    localparam int SETTLE_CYCLES  = 40;                   // quiet inputs at the end
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + RUN_CYCLES + SETTLE_CYCLES);

    logic                  clk;
    logic                  rst_n;
    logic [`ISA_WIDTH-1:0] instr;
    logic [`ISA_WIDTH-1:0] pc_next;
    logic                  uart_complete;
    logic                  keypad_read_enable;
    logic                  keypad_read_complete;
    logic                  cpu_pause;
    logic                  cpu_resume;
    ctrl_vec_t             stage_ctrl;
    cpu_state_t            cpu_state;
    issue_t                issue;
    logic                  uart_disable;
    logic                  disp_req;
    status_msg_t           disp_msg;
    logic                  disp_ack;

    ctrl_vec_t   m_ctrl;                                  // model of the registered outputs
    cpu_state_t  m_state;
    issue_t      m_issue;
    logic        m_uart_dis;
    stage_info_t m_ex;                                    // model tracker records
    stage_info_t m_mem;
    logic        prev_req;                                // display channel at last sample
    status_msg_t prev_msg;
    status_msg_t prev_status;
    int          ack_wait;
    logic        ack_armed;
    int          n_data;                                  // hazard entries per issue
    int          n_pause;
    int          n_uart;
    int          n_keypad;
    int          cycle_cnt;
    int          idle_cnt;                                // samples with req and ack both low

    pipeline_control_top u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .instr                (instr),
        .pc_next              (pc_next),
        .uart_complete        (uart_complete),
        .keypad_read_enable   (keypad_read_enable),
        .keypad_read_complete (keypad_read_complete),
        .cpu_pause            (cpu_pause),
        .cpu_resume           (cpu_resume),
        .stage_ctrl           (stage_ctrl),
        .cpu_state            (cpu_state),
        .issue                (issue),
        .uart_disable         (uart_disable),
        .disp_req             (disp_req),
        .disp_msg             (disp_msg),
        .disp_ack             (disp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                abort_run();
            end
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_ctrl(ctrl_vec_t got, ctrl_vec_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(status_msg_t got, status_msg_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stage(stage_info_t got, stage_info_t exp, string what);
        // dest only means something in a record that writes
        if (got.no_op !== exp.no_op || got.reg_write !== exp.reg_write ||
            got.mem_read !== exp.mem_read || (exp.reg_write && got.dest !== exp.dest)) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic status_msg_t status_of(cpu_state_t s, issue_t i);
        return '{cpu_state: s, issue: i};
    endfunction

    function automatic ctrl_vec_t ctrl_set(stage_ctrl_t c_if, stage_ctrl_t c_id,
                                           stage_ctrl_t c_ex, stage_ctrl_t c_mem);
        ctrl_vec_t v;
        v[`STG_IF]  = c_if;
        v[`STG_ID]  = c_id;
        v[`STG_EX]  = c_ex;
        v[`STG_MEM] = c_mem;
        return v;
    endfunction

    function automatic id_info_t decode_instr(logic [`ISA_WIDTH-1:0] w);
        id_info_t d;
        logic     writer;
        d      = '0;
        writer = 1'b0;
        d.rs   = w[25:21];
        d.rt   = w[20:16];
        case (w[31:26])
            op_rtype: begin
                d.r_type = 1'b1;
                d.jr     = (w[5:0] == funct_jr);
                d.dest   = w[15:11];
                writer   = !d.jr;                         // jr only reads rs
            end
            op_j:           d.jump = 1'b1;
            op_jal: begin
                d.jal  = 1'b1;
                d.dest = '1;                              // $ra
                writer = 1'b1;
            end
            op_beq, op_bne: d.branch = 1'b1;
            op_sw:          d.store  = 1'b1;
            default: begin                                // loads and alu immediates
                d.load   = (w[31:26] == op_lw);
                d.i_type = 1'b1;
                d.dest   = w[20:16];
                writer   = 1'b1;
            end
        endcase
        d.reg_write = writer && (d.dest != '0);
        return d;
    endfunction

    function automatic logic stage_conflict(stage_info_t s, id_info_t d);
        logic rs_hit;
        logic rt_hit;
        rs_hit = !(d.jump || d.jal) && (d.rs == s.dest);
        rt_hit = (d.r_type || d.store || d.branch) && (d.rt == s.dest);
        return !s.no_op && s.reg_write && (rs_hit || rt_hit);
    endfunction

    function automatic stage_info_t advance(stage_ctrl_t c, stage_info_t cur, stage_info_t prev);
        stage_info_t b;
        b       = '0;
        b.no_op = 1'b1;
        case (c)
            ctrl_normal: return prev;
            ctrl_hold:   return cur;
            default:     return b;
        endcase
    endfunction

    task automatic model_step();
        id_info_t    d;
        stage_info_t id_rec;
        stage_info_t nx_ex;
        stage_info_t nx_mem;
        logic        dh;
        logic        resolved;
        d                = decode_instr(instr);
        id_rec           = '0;
        id_rec.reg_write = d.reg_write;
        id_rec.mem_read  = d.load;
        id_rec.dest      = d.dest;
        dh = (d.branch && (stage_conflict(m_ex, d) || stage_conflict(m_mem, d)))
          || (m_ex.mem_read && stage_conflict(m_ex, d));
        nx_ex  = advance(m_ctrl[`STG_EX], m_ex, id_rec);  // tracker follows the old controls
        nx_mem = advance(m_ctrl[`STG_MEM], m_mem, m_ex);
        if (!rst_n) begin
            m_state    = st_idle;
            m_issue    = iss_none;
            m_uart_dis = 1'b1;
            m_ctrl     = ctrl_set(ctrl_normal, ctrl_normal, ctrl_normal, ctrl_normal);
            nx_ex      = advance(ctrl_no_op, m_ex, m_ex);
            nx_mem     = nx_ex;
        end else begin
            case (m_state)
                st_idle: m_state = st_execute;
                st_execute: begin
                    if (dh) begin
                        m_state = st_hazard;
                        m_issue = iss_data;
                        m_ctrl  = ctrl_set(ctrl_hold, ctrl_hold, ctrl_no_op, ctrl_normal);
                        n_data++;
                    end else if (cpu_pause || pc_next > `PC_MAX_VALUE) begin
                        m_state    = st_hazard;
                        m_issue    = cpu_pause ? iss_pause : iss_uart;
                        m_uart_dis = 1'b0;
                        m_ctrl     = ctrl_set(ctrl_no_op, ctrl_normal, ctrl_normal, ctrl_normal);
                        if (cpu_pause) n_pause++;
                        else n_uart++;
                    end else if (keypad_read_enable && !keypad_read_complete) begin
                        m_state = st_interrupt;
                        m_issue = iss_keypad;
                        m_ctrl  = ctrl_set(ctrl_no_op, ctrl_no_op, ctrl_no_op, ctrl_no_op);
                        n_keypad++;
                    end
                end
                st_hazard: begin
                    case (m_issue)
                        iss_data: resolved = !dh;
                        iss_uart: resolved = uart_complete;
                        default:  resolved = cpu_resume && uart_complete;
                    endcase
                    if (resolved) begin
                        m_state    = st_execute;
                        m_issue    = iss_none;
                        m_uart_dis = 1'b1;
                        m_ctrl     = ctrl_set(ctrl_normal, ctrl_normal, ctrl_normal, ctrl_normal);
                    end
                end
                default: begin
                    if (keypad_read_complete) begin       // keypad value entered
                        m_state = st_execute;
                        m_issue = iss_none;
                        m_ctrl  = ctrl_set(ctrl_normal, ctrl_normal, ctrl_normal, ctrl_normal);
                    end
                end
            endcase
        end
        m_ex  = nx_ex;
        m_mem = nx_mem;
    endtask

    // four-phase order, msg stability and message content
    task automatic display_monitor();
        if (!rst_n) begin
            check_bit(disp_req, 1'b0, "disp_req in reset");
        end
        if (disp_req && !prev_req) begin
            check_bit(disp_ack, 1'b0, "ack low when req rose");
            check_bit(disp_msg != prev_msg, 1'b1, "req raised for a changed status");
            check_status(disp_msg, prev_status, "message at req rise");
        end
        if (!disp_req && prev_req) begin
            check_bit(disp_ack, 1'b1, "ack high when req fell");
        end
        if (prev_req || disp_ack) begin
            check_status(disp_msg, prev_msg, "message held during handshake");
        end
        prev_req    = disp_req;
        prev_msg    = disp_msg;
        prev_status = status_of(m_state, m_issue);
    endtask

    task automatic display_responder();
        if (disp_req && !disp_ack) begin
            if (!ack_armed) begin
                ack_wait  = $urandom % 6;                 // 0 to 5 cycles
                ack_armed = 1'b1;
            end
            if (ack_wait == 0) begin
                disp_ack  = 1'b1;
                ack_armed = 1'b0;
            end else begin
                ack_wait--;
            end
        end else if (!disp_req && disp_ack) begin
            disp_ack = 1'b0;
        end
    endtask

    task automatic cycle_step();
        model_step();
        check_ctrl(stage_ctrl, m_ctrl, "stage_ctrl");
        check_status(status_of(cpu_state, issue), status_of(m_state, m_issue), "cpu status");
        check_bit(uart_disable, m_uart_dis, "uart_disable");
        check_stage(u_dut.ex_info, m_ex, "execute record");
        check_stage(u_dut.mem_info, m_mem, "memory record");
        display_monitor();
        display_responder();
    endtask

    task automatic drive_random();
        int unsigned                pick;
        logic [5:0]                 op;
        logic [5:0]                 funct;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        pick  = $urandom % 16;
        rs    = `REG_ADDR_WIDTH'($urandom % 4);          // few registers so conflicts are frequent
        rt    = `REG_ADDR_WIDTH'($urandom % 4);
        rd    = `REG_ADDR_WIDTH'($urandom % 4);
        funct = (pick == 0) ? funct_jr : 6'($urandom);
        case (pick)
            5, 6, 7: op = op_lw;
            8, 9:    op = op_sw;
            10:      op = op_beq;
            11:      op = op_bne;
            12:      op = op_j;
            13:      op = op_jal;
            14, 15:  op = 6'h08;                          // addi
            default: op = op_rtype;
        endcase
        if (m_ctrl[`STG_IF] != ctrl_hold) begin           // held if/id keeps its word
            if (op == op_rtype) begin
                instr = {op, rs, rt, rd, 5'd0, funct};
            end else begin
                instr = {op, rs, rt, 16'($urandom)};
            end
        end
        pc_next = ($urandom % 40 == 0) ? `PC_MAX_VALUE + 32'd4 + 32'($urandom % 64)
                                       : $urandom % (`PC_MAX_VALUE + 32'd1);
        cpu_pause            = ($urandom % 50 == 0);
        cpu_resume           = ($urandom % 3 == 0);
        uart_complete        = ($urandom % 3 == 0);
        keypad_read_enable   = ($urandom % 25 == 0);
        keypad_read_complete = ($urandom % 4 == 0);
    endtask

    task automatic drive_quiet();
        if (m_ctrl[`STG_IF] != ctrl_hold) begin
            instr = '0;                                   // sll $0 touches no register
        end
        pc_next              = '0;
        cpu_pause            = 1'b0;
        cpu_resume           = 1'b1;
        uart_complete        = 1'b1;
        keypad_read_enable   = 1'b0;
        keypad_read_complete = 1'b1;
    endtask

    initial begin
        void'($urandom(99));
        rst_n                = 1'b0;
        instr                = '0;
        pc_next              = '0;
        uart_complete        = 1'b0;
        keypad_read_enable   = 1'b0;
        keypad_read_complete = 1'b0;
        cpu_pause            = 1'b0;
        cpu_resume           = 1'b0;
        disp_ack             = 1'b0;
        ack_wait             = 0;
        ack_armed            = 1'b0;
        prev_req             = 1'b0;
        prev_msg             = status_of(st_idle, iss_none);
        prev_status          = prev_msg;
        n_data               = 0;
        n_pause              = 0;
        n_uart               = 0;
        n_keypad             = 0;
        idle_cnt             = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            cycle_step();
        end
        rst_n = 1'b1;
        for (int i = 0; i < RUN_CYCLES; i++) begin
            @(negedge clk);
            cycle_step();
            drive_random();
        end
        for (int i = 0; i < 10; i++) begin                // let the pipe drain
            @(negedge clk);
            cycle_step();
            drive_quiet();
        end
        while (idle_cnt < 3) begin                        // reporter back in idle and compared again
            @(negedge clk);
            cycle_step();
            drive_quiet();
            if (disp_req || disp_ack) begin
                idle_cnt = 0;
            end else begin
                idle_cnt++;
            end
        end
        check_status(status_of(cpu_state, issue), status_of(st_execute, iss_none), "settled status");
        check_status(disp_msg, status_of(m_state, m_issue), "last message sent");
        if (n_data == 0 || n_pause == 0 || n_uart == 0 || n_keypad == 0) begin
            $display("Not every issue was reached: data %0d pause %0d uart %0d keypad %0d",
                     n_data, n_pause, n_uart, n_keypad);
            abort_run();
        end else begin
            $display("issues entered: data %0d pause %0d uart %0d keypad %0d",
                     n_data, n_pause, n_uart, n_keypad);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* list.f */
+incdir+include
src/isa_pkg.sv
src/ctrl_pkg.sv
src/instr_classifier.sv
src/stage_tracker.sv
src/hazard_unit.sv
src/status_reporter.sv
src/pipeline_control_top.sv
verification/tb_pipeline_control.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then scan the log for the fail message
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -f list.f --top-module tb_pipeline_control \
    -o tb_sim > "$LOG" 2>&1 &&
    ./obj_dir/tb_sim >> "$LOG" 2>&1 ||
    echo "*** TEST FAILED ***" >> "$LOG"
cat "$LOG"
grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG" && exit 1 || exit 0
